// File: maze_board.f
common/maze_pkg.sv
hw/maze_rom.sv
hw/row_counter.sv
hw/reload_fsm.sv
hw/board_store.sv
hw/maze_board.sv
testbench/tb_clock.sv
testbench/maze_board_assertions.sv
testbench/maze_board_tb.sv

// File: Makefile
TOP = maze_board_tb

.PHONY: all lint clean

# build, run, then decide pass or fail from the log
all:
	verilator --binary --timing --assert -f maze_board.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) 2>&1 | tee sim.log
	grep -q "Simulation PASSED" sim.log

lint:
	verilator --lint-only --timing -Wall -f maze_board.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// File: hw/maze_rows.hex
// one 28-bit wall mask per line, row 0 first; bit j set means column j is a wall
0000000
0000000
0000000
FFFFFFF
8006001
BDF6FBD
BDF6FBD
BDF6FBD
8000001
BD9F9BD
BD9F9BD
8186181
FD861BF
0D801B0
0D9F9B0
FC1083F
0010800
FC1F83F
0D801B0
0DBFFB0
FDBFFBF
8006001
BDF6FBD
BDF6FBD
8E00071
ED9F9B7
ED9F9B7
8186181
BFF6FFD
BFF6FFD
8000001
FFFFFFF
0000000
0000000
0000000
0000000

// File: testbench/maze_board_tb.sv
`timescale 1ns/1ps

module maze_board_tb import maze_pkg::*; ();

	// reset length and reload length from E0 to done
	localparam int RESET_CYCLES  = 10;
	localparam int RELOAD_CYCLES = 37;
	// watchdog budget covers 8 reloads, three resets and a margin
	localparam int WATCHDOG_CYCLES = 8 * RELOAD_CYCLES + 3 * (RESET_CYCLES + 1) + 200;

	logic   clk;
	logic   rst_n;
	logic   reload;
	logic   reload_done;
	board_t board;

	// expected boards
	board_t    ref_board;
	board_t    empty_board;
	row_mask_t ref_rows [BOARD_ROWS];

	tb_clock u_tb_clock (
		.o_clk (clk)
	);

	maze_board DUT (
		.i_clk         (clk),
		.i_rst_n       (rst_n),
		.i_reload      (reload),
		.o_reload_done (reload_done),
		.o_board       (board)
	);

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_done(input logic actual, input logic expected, input string when);
		if (actual !== expected) begin
			stop_on_error($sformatf("CHECK FAILED: o_reload_done %s got 0x%0h expected 0x%0h",
				when, actual, expected));
		end
	endtask

	// reports the first mismatching tile only
	task automatic check_board(input board_t actual, input board_t expected, input string when);
		int bad_row;
		int bad_col;
		bad_row = -1;
		bad_col = -1;
		for (int r = 0; r < BOARD_ROWS; r++) begin
			for (int c = 0; c < BOARD_COLS; c++) begin
				if (bad_row < 0 && actual[r][c] !== expected[r][c]) begin
					bad_row = r;
					bad_col = c;
				end
			end
		end
		if (bad_row >= 0) begin
			stop_on_error($sformatf(
				"CHECK FAILED: o_board[%0d][%0d] %s got 0x%02h expected 0x%02h",
				bad_row, bad_col, when, actual[bad_row][bad_col],
				expected[bad_row][bad_col]));
		end
	endtask

	// wall bit to wall tile and anything else to path
	task automatic build_reference();
		$readmemh(MAZE_FILE, ref_rows);
		for (int r = 0; r < BOARD_ROWS; r++) begin
			for (int c = 0; c < BOARD_COLS; c++) begin
				ref_board[r][c]   = ref_rows[r][c] ? TILE_WALL : TILE_PATH;
				empty_board[r][c] = TILE_PATH;
			end
		end
		// an all path layout would make the board checks blind
		if (ref_board == empty_board) begin
			stop_on_error("layout file missing or holds no walls");
		end
	endtask

	task automatic apply_reset();
		@(posedge clk);
		rst_n <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
	endtask

	// one reload from the request to E37
	// extra_at above 0 adds a second pulse that E(extra_at+1) samples
	// samples sit at the falling edge half a cycle clear of the drive
	task automatic run_reload(input int extra_at, input bit board_each_cycle);
		@(posedge clk);
		reload <= 1'b1;
		// E0, request taken
		@(posedge clk);
		reload <= 1'b0;
		@(negedge clk);
		check_done(reload_done, 1'b0, "after E0");
		for (int k = 1; k <= RELOAD_CYCLES; k++) begin
			@(posedge clk);
			reload <= (k == extra_at);
			@(negedge clk);
			check_done(reload_done, logic'(k == RELOAD_CYCLES), $sformatf("after E%0d", k));
			if (board_each_cycle) begin
				check_board(board, ref_board, $sformatf("after E%0d", k));
			end
		end
	endtask

	// idle cycles in which done and board must not move
	task automatic hold_idle(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			check_done(reload_done, 1'b1, "while idle");
			check_board(board, ref_board, "while idle");
		end
	endtask

	task automatic after_reset_state();
		check_done(reload_done, 1'b0, "after reset");
		check_board(board, empty_board, "after reset");
	endtask

	task automatic reload_done_timing();
		run_reload(0, 1'b0);
	endtask

	task automatic board_after_reload();
		check_board(board, ref_board, "after E37");
		hold_idle(3);
	endtask

	// start from an empty board so the compare means something
	task automatic ignored_mid_pulse();
		apply_reset();
		check_board(board, empty_board, "before reload");
		run_reload(17, 1'b0);
		check_board(board, ref_board, "after E37");
		hold_idle(5);
	endtask

	task automatic second_reload();
		check_done(reload_done, 1'b1, "before second reload");
		run_reload(0, 1'b1);
		hold_idle(2);
	endtask

	task automatic reset_after_load();
		@(posedge clk);
		rst_n <= 1'b0;
		@(negedge clk);
		// asynchronous reset visible before the next edge
		check_done(reload_done, 1'b0, "in reset");
		check_board(board, empty_board, "in reset");
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		repeat (3) begin
			@(negedge clk);
			check_done(reload_done, 1'b0, "after reset release");
			check_board(board, empty_board, "after reset release");
		end
	endtask

	initial begin
		rst_n  = 1'b0;
		reload = 1'b0;
		build_reference();
		apply_reset();
		after_reset_state();
		reload_done_timing();
		board_after_reload();
		ignored_mid_pulse();
		second_reload();
		reset_after_load();
		$display("Simulation PASSED");
		$finish;
	end

	// hang guard
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		stop_on_error($sformatf("timeout, run not finished after %0d cycles", WATCHDOG_CYCLES));
	end

endmodule

// File: testbench/maze_board_assertions.sv
`timescale 1ns/1ps

module maze_board_assertions import maze_pkg::*; (
	input logic        i_clk,
	input logic        i_rst_n,
	// FSM state
	input load_state_t i_state,
	// done level at the top level port
	input logic        i_done,
	// record from the layout table
	input row_wr_t     i_row_wr
);

	// cycles spent in LOAD so far
	int   load_len;
	// reload running
	logic in_sweep;

	assign in_sweep = (i_state == LOAD) || (i_state == DRAIN);

	// counts up through LOAD, holds the total in DRAIN
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			load_len <= 0;
		end else if (i_state == LOAD) begin
			load_len <= load_len + 1;
		end else begin
			load_len <= 0;
		end
	end

	// done never high while rows are moving
	done_low_in_sweep: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		in_sweep |-> !i_done)
		else $error("reload done high during LOAD or DRAIN");

	// records only come out of a sweep
	record_in_sweep: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_row_wr.valid |-> in_sweep)
		else $error("row record valid outside LOAD and DRAIN");

	// one LOAD cycle per board row
	load_not_long: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(i_state == LOAD) |-> (load_len < BOARD_ROWS))
		else $error("LOAD ran past the last row");
	load_exact: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(i_state == DRAIN) |-> (load_len == BOARD_ROWS))
		else $error("LOAD did not last one cycle per row");

	// done follows DRAIN by one cycle, and only DRAIN
	done_after_drain: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(i_state == DRAIN) |=> i_done)
		else $error("done not set one cycle after DRAIN");
	done_from_drain: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		$rose(i_done) |-> ($past(i_state) == DRAIN))
		else $error("done rose without a DRAIN cycle before it");

endmodule

// sits at the top level, where both the FSM state and the record are in reach
bind maze_board maze_board_assertions u_maze_board_assertions (
	.i_clk    (i_clk),
	.i_rst_n  (i_rst_n),
	.i_state  (u_reload_fsm.state_q),
	.i_done   (o_reload_done),
	.i_row_wr (row_wr)
);

// File: testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	// free running testbench clock
	output logic o_clk
);

	// 100 ns period
	localparam int HALF_PERIOD_NS = 50;

	initial begin
		o_clk = 1'b0;
		forever begin
			#(HALF_PERIOD_NS) o_clk = ~o_clk;
		end
	end

endmodule

// File: hw/maze_board.sv
`timescale 1ns/1ps

module maze_board import maze_pkg::*; (
	input  logic   i_clk,
	input  logic   i_rst_n,

	// reload request, one-cycle pulse
	input  logic   i_reload,
	// level, high once the board matches the layout
	output logic   o_reload_done,

	// all tiles, [row][col]
	output board_t o_board
);

	// FSM to counter
	logic      clear;
	logic      step;
	// counter back to FSM
	logic      last_row;

	// FSM to layout table
	logic      rd;
	// counter address into the table
	row_addr_t row;

	// table record into the board
	row_wr_t   row_wr;

	// sequencing and done level
	reload_fsm u_reload_fsm (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_reload      (i_reload),
		.i_last_row    (last_row),
		.o_clear       (clear),
		.o_step        (step),
		.o_rd          (rd),
		.o_reload_done (o_reload_done)
	);

	// row address for the sweep
	row_counter u_row_counter (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_clear    (clear),
		.i_step     (step),
		.o_row      (row),
		.o_last_row (last_row)
	);

	// layout table
	// one cycle read, record trails the address by one edge
	maze_rom u_maze_rom (
		.i_clk    (i_clk),
		.i_rst_n  (i_rst_n),
		.i_rd     (rd),
		.i_row    (row),
		.o_row_wr (row_wr)
	);

	// tile registers
	// a record is written one edge after it is registered
	board_store u_board_store (
		.i_clk    (i_clk),
		.i_rst_n  (i_rst_n),
		.i_row_wr (row_wr),
		.o_board  (o_board)
	);

endmodule

// File: hw/board_store.sv
`timescale 1ns/1ps

module board_store import maze_pkg::*; (
	input  logic    i_clk,
	input  logic    i_rst_n,

	// row record from the layout table
	input  row_wr_t i_row_wr,

	// every tile, in parallel
	output board_t  o_board
);

	// tile registers, 1008 of them
	board_t board_q;

	// incoming row expanded to tile codes
	tile_t [BOARD_COLS-1:0] row_tiles;

	// mask bit to tile code, column by column
	always_comb begin
		for (int c = 0; c < BOARD_COLS; c++) begin
			if (i_row_wr.mask[c]) begin
				row_tiles[c] = TILE_WALL;
			end else begin
				row_tiles[c] = TILE_PATH;
			end
		end
	end

	// whole addressed row replaced on a valid record
	// other rows keep their tiles
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			// empty board, all open path
			for (int r = 0; r < BOARD_ROWS; r++) begin
				for (int c = 0; c < BOARD_COLS; c++) begin
					board_q[r][c] <= TILE_PATH;
				end
			end
		end else if (i_row_wr.valid) begin
			// row index is always below BOARD_ROWS while valid
			board_q[i_row_wr.row] <= row_tiles;
		end
	end

	// board straight out of the registers
	assign o_board = board_q;

endmodule

// File: hw/reload_fsm.sv
`timescale 1ns/1ps

module reload_fsm import maze_pkg::*; (
	input  logic i_clk,
	input  logic i_rst_n,

	// one-cycle reload request
	// only honoured in IDLE
	input  logic i_reload,
	// counter is at the final row
	input  logic i_last_row,

	// zero the row counter
	output logic o_clear,
	// advance the row counter
	output logic o_step,
	// read the layout table
	output logic o_rd,
	// board holds a complete layout
	output logic o_reload_done
);

	// FSM state
	load_state_t state_q;
	load_state_t state_d;

	// done level
	logic done_q;
	logic done_d;

	// sweep in progress
	logic in_load;

	// next state and done level
	// IDLE   waits for a request
	// LOAD   one row read per cycle, 36 cycles
	// DRAIN  last record lands in the board
	always_comb begin
		state_d = state_q;
		done_d  = done_q;
		o_clear = 1'b0;
		case (state_q)
			IDLE: begin
				if (i_reload) begin
					// accept, restart the sweep at row 0
					state_d = LOAD;
					done_d  = 1'b0;
					o_clear = 1'b1;
				end
			end
			LOAD: begin
				// last row read at the edge ending this cycle
				if (i_last_row) begin
					state_d = DRAIN;
				end
			end
			DRAIN: begin
				// row 35 is written on the same edge
				// so done and the full board appear together
				state_d = IDLE;
				done_d  = 1'b1;
			end
			default: begin
				state_d = IDLE;
			end
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state_q <= IDLE;
			done_q  <= 1'b0;
		end else begin
			state_q <= state_d;
			done_q  <= done_d;
		end
	end

	// step and read are levels for the whole of LOAD
	assign in_load = (state_q == LOAD);
	assign o_step  = in_load;
	assign o_rd    = in_load;

	// done straight from its register
	assign o_reload_done = done_q;

endmodule

// File: hw/row_counter.sv
`timescale 1ns/1ps

module row_counter import maze_pkg::*; (
	input  logic      i_clk,
	input  logic      i_rst_n,

	// zero the address, start of a sweep
	input  logic      i_clear,
	// advance one row
	input  logic      i_step,

	// current row address
	output row_addr_t o_row,
	// address is the final board row
	output logic      o_last_row
);

	// last index of a sweep
	// the only place that knows how many rows a reload covers
	localparam row_addr_t LAST_ROW = row_addr_t'(BOARD_ROWS - 1);

	// row address register
	row_addr_t row_q;
	// next address
	row_addr_t row_d;

	// clear wins over step
	// the FSM never raises both, but a new sweep must start at 0
	always_comb begin
		row_d = row_q;
		if (i_clear) begin
			row_d = '0;
		end else if (i_step) begin
			row_d = row_q + row_addr_t'(1);
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			row_q <= '0;
		end else begin
			row_q <= row_d;
		end
	end

	assign o_row = row_q;

	// high during the cycle the last row is being read
	// the FSM leaves LOAD on the edge that ends this cycle
	assign o_last_row = (row_q == LAST_ROW);

endmodule

// File: hw/maze_rom.sv
`timescale 1ns/1ps

module maze_rom import maze_pkg::*; (
	input  logic      i_clk,
	input  logic      i_rst_n,

	// read request from the reload FSM
	input  logic      i_rd,
	// row address from the sweep counter
	input  row_addr_t i_row,

	// registered row record towards the board store
	output row_wr_t   o_row_wr
);

	// layout table, one wall mask per row
	// read only, filled at elaboration
	row_mask_t rows [BOARD_ROWS];

	// record payload, address and mask
	row_addr_t row_q;
	row_mask_t mask_q;
	// record valid flag
	logic      valid_q;

	initial begin
		$readmemh(MAZE_FILE, rows);
	end

	// synchronous read on the rising edge
	// payload only moves on a read, so the counter running
	// one past the last row never indexes outside the table
	always_ff @(posedge i_clk) begin
		if (i_rd) begin
			// keep the index alongside the data
			row_q  <= i_row;
			mask_q <= rows[i_row];
		end
	end

	// valid follows the read level one cycle later
	// cleared by reset so nothing is written out of reset
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= i_rd;
		end
	end

	// pack the record
	always_comb begin
		o_row_wr.valid = valid_q;
		o_row_wr.row   = row_q;
		o_row_wr.mask  = mask_q;
	end

endmodule

// File: common/maze_pkg.sv
package maze_pkg;

	// board geometry, rows top to bottom
	localparam int BOARD_ROWS = 36;
	// columns left to right
	localparam int BOARD_COLS = 28;

	// enough bits to index 36 rows
	localparam int ROW_ADDR_W = 6;
	// one tile code per board cell
	localparam int TILE_W = 8;

	// layout table, one 28-bit wall mask per line, row 0 first
	localparam string MAZE_FILE = "hw/maze_rows.hex";

	// a single tile code
	typedef logic [TILE_W-1:0] tile_t;

	// index of one board row
	typedef logic [ROW_ADDR_W-1:0] row_addr_t;

	// wall mask of one row
	// bit j set means column j is a wall
	typedef logic [BOARD_COLS-1:0] row_mask_t;

	// tile codes used by the layout
	// everything that is not a wall is open path
	localparam tile_t TILE_PATH = tile_t'(0);
	localparam tile_t TILE_WALL = tile_t'(1);

	// full board, indexed [row][col]
	// 36 x 28 x 8 = 8064 bits
	typedef tile_t [BOARD_ROWS-1:0][BOARD_COLS-1:0] board_t;

	// one row on its way from the layout table to the board
	// valid high means write it at the next edge
	typedef struct packed {
		logic      valid;
		row_addr_t row;
		row_mask_t mask;
	} row_wr_t;

	// reload sequencing
	// DRAIN waits for the last record to land in the board
	typedef enum logic [1:0] {
		IDLE  = 2'd0,
		LOAD  = 2'd1,
		DRAIN = 2'd2
	} load_state_t;

endpackage
